// ==== lc3_pkg.sv ====
// shared widths, opcodes, memory bus structs and fsm/writeback enums for the lc3 core
`default_nettype none

package lc3_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////

    // one machine word, data and address alike
    typedef logic [15:0] word_t;

    // general register index
    typedef logic [2:0]  reg_idx_t;

    // instruction bits 15:12
    typedef logic [3:0]  opcode_t;

    // condition codes, n in bit 2, z in bit 1, p in bit 0
    typedef logic [2:0]  nzp_t;

    ////////////////////////////////////////////////////////////
    // opcodes kept by the core
    ////////////////////////////////////////////////////////////

    localparam opcode_t OP_BR  = 4'b0000;
    localparam opcode_t OP_ADD = 4'b0001;
    localparam opcode_t OP_LD  = 4'b0010;
    localparam opcode_t OP_ST  = 4'b0011;
    localparam opcode_t OP_JSR = 4'b0100;
    localparam opcode_t OP_AND = 4'b0101;
    localparam opcode_t OP_LDR = 4'b0110;
    localparam opcode_t OP_STR = 4'b0111;
    localparam opcode_t OP_NOT = 4'b1001;
    // jmp with base r7 is ret
    localparam opcode_t OP_JMP = 4'b1100;
    localparam opcode_t OP_LEA = 4'b1110;
    // ldi, sti, trap, rti and 1101 fall through as no-ops

    ////////////////////////////////////////////////////////////
    // architectural constants
    ////////////////////////////////////////////////////////////

    localparam int       NUM_REGS = 8;

    // jsr/jsrr return address lands here
    localparam reg_idx_t LINK_REG = 3'd7;

    // first fetch address
    localparam word_t    PC_RESET = 16'h3000;

    // flags out of reset, z only
    localparam nzp_t     NZP_Z    = 3'b010;

    ////////////////////////////////////////////////////////////
    // memory port
    ////////////////////////////////////////////////////////////

    // request, held stable until the response cycle
    typedef struct packed {
        logic  valid;
        logic  we;
        word_t addr;
        word_t wdata;
    } mem_req_t;

    // response, rdata only meaningful for reads
    typedef struct packed {
        logic  valid;
        word_t rdata;
    } mem_rsp_t;

    ////////////////////////////////////////////////////////////
    // control encodings
    ////////////////////////////////////////////////////////////

    // writeback source
    typedef enum logic [1:0] {
        WB_ALU,
        WB_ADDR,
        WB_MEM,
        WB_LINK
    } wb_sel_t;

    // sequencer states
    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXEC,
        MEM,
        WB
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== lc3_regfile.sv ====
// eight-entry general register file, two async read ports, one sync write port
`timescale 1ns/1ps
`default_nettype none

module lc3_regfile (
    input  logic              clk,
    input  logic              rst_n,
    input  lc3_pkg::reg_idx_t rd_a,
    input  lc3_pkg::reg_idx_t rd_b,
    input  logic              wr_en,
    input  lc3_pkg::reg_idx_t wr_idx,
    input  lc3_pkg::word_t    wr_data,
    output lc3_pkg::word_t    ra,
    output lc3_pkg::word_t    rb
);

    import lc3_pkg::*;

    // r0..r7
    word_t regs [NUM_REGS];

    ////////////////////////////////////////////////////////////
    // write port
    ////////////////////////////////////////////////////////////

    // architectural state, so all registers start at zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // read ports
    ////////////////////////////////////////////////////////////

    // combinational, old value seen in the write cycle
    assign ra = regs[rd_a];
    assign rb = regs[rd_b];

endmodule

`default_nettype wire

// ==== lc3_alu.sv ====
// operate datapath for add, and, not with imm5 operand select
`timescale 1ns/1ps
`default_nettype none

module lc3_alu (
    input  lc3_pkg::word_t instr,
    input  lc3_pkg::word_t ra,
    input  lc3_pkg::word_t rb,
    output lc3_pkg::word_t result
);

    import lc3_pkg::*;

    opcode_t op;
    word_t   imm5;
    word_t   opnd_b;

    assign op = instr[15:12];

    // imm5 sign extended to a full word
    assign imm5 = {{11{instr[4]}}, instr[4:0]};

    // bit 5 picks immediate over sr2
    assign opnd_b = instr[5] ? imm5 : rb;

    ////////////////////////////////////////////////////////////
    // operation
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (op)
            OP_ADD:  result = ra + opnd_b;
            OP_AND:  result = ra & opnd_b;
            // not ignores bits 5:0
            OP_NOT:  result = ~ra;
            default: result = '0;
        endcase
    end

    // known operands and instruction must give a known result
    always_comb begin
        if (!$isunknown({instr, ra, rb})) begin
            assert (!$isunknown(result))
            else $error("alu result has unknown bits for known inputs");
        end
    end

endmodule

`default_nettype wire

// ==== lc3_addr_gen.sv ====
// effective address and jump target generation from pc, base register and offsets
`timescale 1ns/1ps
`default_nettype none

module lc3_addr_gen (
    input  lc3_pkg::word_t instr,
    input  lc3_pkg::word_t pc,
    input  lc3_pkg::word_t ra,
    output lc3_pkg::word_t addr
);

    import lc3_pkg::*;

    opcode_t op;
    word_t   off6;
    word_t   off9;
    word_t   off11;

    assign op = instr[15:12];

    // sign-extended offsets
    assign off6  = {{10{instr[5]}}, instr[5:0]};
    assign off9  = {{7{instr[8]}}, instr[8:0]};
    assign off11 = {{5{instr[10]}}, instr[10:0]};

    ////////////////////////////////////////////////////////////
    // address select
    ////////////////////////////////////////////////////////////

    // pc here is already incremented past this instruction
    always_comb begin
        case (op)
            OP_BR, OP_LD, OP_ST, OP_LEA: begin
                addr = pc + off9;
            end
            OP_JSR: begin
                // bit 11 set is jsr, clear is jsrr
                if (instr[11]) begin
                    addr = pc + off11;
                end else begin
                    addr = ra;
                end
            end
            OP_LDR, OP_STR: begin
                addr = ra + off6;
            end
            // jmp and ret
            OP_JMP:  addr = ra;
            default: addr = pc;
        endcase
    end

endmodule

`default_nettype wire

// ==== lc3_writeback.sv ====
// writeback source mux, n/z/p flag register and branch condition
`timescale 1ns/1ps
`default_nettype none

module lc3_writeback (
    input  logic             clk,
    input  logic             rst_n,
    input  lc3_pkg::wb_sel_t wb_sel,
    input  logic             wb_en,
    input  lc3_pkg::word_t   alu_result,
    input  lc3_pkg::word_t   addr_result,
    input  lc3_pkg::word_t   mem_data,
    input  lc3_pkg::word_t   link_pc,
    input  lc3_pkg::nzp_t    br_mask,
    output lc3_pkg::word_t   wb_data,
    output logic             br_taken
);

    import lc3_pkg::*;

    word_t mem_q;
    nzp_t  flags;

    // read data of the response cycle, lines up with the wb cycle after it
    always_ff @(posedge clk) begin
        mem_q <= mem_data;
    end

    always_comb begin
        case (wb_sel)
            WB_ALU:  wb_data = alu_result;
            WB_ADDR: wb_data = addr_result;
            WB_MEM:  wb_data = mem_q;
            default: wb_data = link_pc;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // condition codes
    ////////////////////////////////////////////////////////////

    // link write from jsr keeps the flags
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flags <= NZP_Z;
        end else if (wb_en && (wb_sel != WB_LINK)) begin
            flags <= {wb_data[15], wb_data == '0, !wb_data[15] && (wb_data != '0)};
        end
    end

    // any mask bit matching a set flag
    assign br_taken = |(br_mask & flags);

    a_flags_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot(flags))
    else $error("condition codes not one-hot");

endmodule

`default_nettype wire

// ==== lc3_control.sv ====
// instruction sequencer fsm, instruction register, pc and memory request register
`timescale 1ns/1ps
`default_nettype none

module lc3_control (
    input  logic              clk,
    input  logic              rst_n,
    output lc3_pkg::mem_req_t mem_req,
    input  lc3_pkg::mem_rsp_t mem_rsp,
    output lc3_pkg::word_t    instr,
    output lc3_pkg::word_t    pc,
    output lc3_pkg::reg_idx_t rd_a,
    output lc3_pkg::reg_idx_t rd_b,
    output logic              wr_en,
    output lc3_pkg::reg_idx_t wr_idx,
    output lc3_pkg::wb_sel_t  wb_sel,
    output logic              wb_en,
    input  lc3_pkg::word_t    addr_result,
    input  lc3_pkg::word_t    store_data,
    input  logic              br_taken
);

    import lc3_pkg::*;

    ctrl_state_t state;
    word_t       ir;
    word_t       pc_q;
    mem_req_t    req_q;

    opcode_t     op;
    logic        is_load;
    logic        is_store;
    logic        writes_reg;
    logic        acc_done;

    ////////////////////////////////////////////////////////////
    // decode
    ////////////////////////////////////////////////////////////

    assign op         = ir[15:12];
    assign is_load    = (op == OP_LD) || (op == OP_LDR);
    assign is_store   = (op == OP_ST) || (op == OP_STR);
    assign writes_reg = is_load || (op inside {OP_ADD, OP_AND, OP_NOT, OP_LEA, OP_JSR});

    // sr1 / base register
    assign rd_a   = ir[8:6];
    // stores read their source through port b
    assign rd_b   = is_store ? ir[11:9] : ir[2:0];
    assign wr_idx = (op == OP_JSR) ? LINK_REG : ir[11:9];

    always_comb begin
        case (op)
            OP_LEA:        wb_sel = WB_ADDR;
            OP_LD, OP_LDR: wb_sel = WB_MEM;
            OP_JSR:        wb_sel = WB_LINK;
            default:       wb_sel = WB_ALU;
        endcase
    end

    // outstanding access answered this cycle
    assign acc_done = req_q.valid && mem_rsp.valid;

    ////////////////////////////////////////////////////////////
    // sequencer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= FETCH;
            pc_q  <= PC_RESET;
            req_q <= '0;
        end else begin
            case (state)
                FETCH: begin
                    // raise fetch, then wait for its response
                    if (!req_q.valid) begin
                        req_q.valid <= 1'b1;
                        req_q.we    <= 1'b0;
                        req_q.addr  <= pc_q;
                        req_q.wdata <= '0;
                    end else if (mem_rsp.valid) begin
                        req_q.valid <= 1'b0;
                        pc_q        <= pc_q + 16'd1;
                        state       <= DECODE;
                    end
                end
                // register indices settle from the new ir
                DECODE: state <= EXEC;
                EXEC: begin
                    if (is_load || is_store) begin
                        req_q.valid <= 1'b1;
                        req_q.we    <= is_store;
                        req_q.addr  <= addr_result;
                        req_q.wdata <= store_data;
                        state       <= MEM;
                    end else if (writes_reg) begin
                        state <= WB;
                    end else begin
                        // br, jmp, and every dropped opcode end here
                        if (((op == OP_BR) && br_taken) || (op == OP_JMP)) begin
                            pc_q <= addr_result;
                        end
                        state <= FETCH;
                    end
                end
                MEM: begin
                    if (mem_rsp.valid) begin
                        req_q.valid <= 1'b0;
                        if (is_load) begin
                            state <= WB;
                        end else begin
                            state <= FETCH;
                        end
                    end
                end
                WB: begin
                    // jsr redirects on the same edge that writes r7 with the old pc
                    if (op == OP_JSR) begin
                        pc_q <= addr_result;
                    end
                    state <= FETCH;
                end
                default: state <= FETCH;
            endcase
        end
    end

    // instruction register, loaded on fetch response only
    always_ff @(posedge clk) begin
        if ((state == FETCH) && acc_done) begin
            ir <= mem_rsp.rdata;
        end
    end

    assign mem_req = req_q;
    assign instr   = ir;
    assign pc      = pc_q;
    assign wr_en   = (state == WB);
    assign wb_en   = (state == WB);

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        req_q.valid && !mem_rsp.valid |=> $stable(req_q))
    else $error("memory request changed while waiting for response");

    a_no_fetch_write: assert property (@(posedge clk) disable iff (!rst_n)
        (state == FETCH) && req_q.valid |-> !req_q.we)
    else $error("write request outstanding during fetch");

endmodule

`default_nettype wire

// ==== lc3_core.sv ====
// lc3 core top level, sequencer plus regfile, alu, address generator and writeback
`timescale 1ns/1ps
`default_nettype none

module lc3_core (
    input  logic              clk,
    input  logic              rst_n,
    output lc3_pkg::mem_req_t mem_req,
    input  lc3_pkg::mem_rsp_t mem_rsp
);

    import lc3_pkg::*;

    // control to datapath
    word_t    instr;
    word_t    pc;
    reg_idx_t rd_a;
    reg_idx_t rd_b;
    logic     wr_en;
    reg_idx_t wr_idx;
    wb_sel_t  wb_sel;
    logic     wb_en;

    // datapath results
    word_t    ra;
    word_t    rb;
    word_t    alu_result;
    word_t    addr_result;
    word_t    wb_data;
    logic     br_taken;

    ////////////////////////////////////////////////////////////
    // instances
    ////////////////////////////////////////////////////////////

    lc3_control u_control (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_req     (mem_req),
        .mem_rsp     (mem_rsp),
        .instr       (instr),
        .pc          (pc),
        .rd_a        (rd_a),
        .rd_b        (rd_b),
        .wr_en       (wr_en),
        .wr_idx      (wr_idx),
        .wb_sel      (wb_sel),
        .wb_en       (wb_en),
        .addr_result (addr_result),
        .store_data  (rb),
        .br_taken    (br_taken)
    );

    lc3_regfile u_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_a    (rd_a),
        .rd_b    (rd_b),
        .wr_en   (wr_en),
        .wr_idx  (wr_idx),
        .wr_data (wb_data),
        .ra      (ra),
        .rb      (rb)
    );

    lc3_alu u_alu (
        .instr  (instr),
        .ra     (ra),
        .rb     (rb),
        .result (alu_result)
    );

    lc3_addr_gen u_addr_gen (
        .instr (instr),
        .pc    (pc),
        .ra    (ra),
        .addr  (addr_result)
    );

    // pc doubles as the link value for jsr
    lc3_writeback u_writeback (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb_sel      (wb_sel),
        .wb_en       (wb_en),
        .alu_result  (alu_result),
        .addr_result (addr_result),
        .mem_data    (mem_rsp.rdata),
        .link_pc     (pc),
        .br_mask     (instr[11:9]),
        .wb_data     (wb_data),
        .br_taken    (br_taken)
    );

endmodule

`default_nettype wire

// ==== tb_lc3_model.svh ====
// isa reference model, bus transaction record, lcg and program images for the lc3 testbench
`ifndef TB_LC3_MODEL_SVH
`define TB_LC3_MODEL_SVH

////////////////////////////////////////////////////////////
// expected bus traffic
////////////////////////////////////////////////////////////

typedef struct packed {
    logic        we;
    logic [15:0] addr;
    logic [15:0] data;
} bus_txn_t;

localparam int MAX_TXN   = 256;
localparam int MAX_INSTR = 200;

bus_txn_t    exp_txn [0:MAX_TXN-1];
int          exp_cnt;
// initial memory of the current test and the model's own copy
logic [15:0] image [0:65535];
logic [15:0] rmem [0:65535];
string       test_name;

// 32-bit lcg with numerical recipes constants
function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

// field of width bits in the low bits with its sign in bit bits-1
function automatic logic [15:0] sign_extend(input logic [15:0] ir, input int bits);
    logic [15:0] m;
    m = (16'd1 << bits) - 16'd1;
    return ir[bits-1] ? (ir | ~m) : (ir & m);
endfunction

function automatic void add_txn(input logic we, input logic [15:0] addr,
                                input logic [15:0] data);
    if (exp_cnt < MAX_TXN) begin
        exp_txn[exp_cnt] = '{we: we, addr: addr, data: data};
    end
    exp_cnt++;
endfunction

////////////////////////////////////////////////////////////
// reference execution returning the instruction count
////////////////////////////////////////////////////////////

function automatic int run_model();
    logic [15:0] r [8];
    logic [15:0] pc;
    logic [15:0] ir;
    logic [15:0] a;
    logic [15:0] v;
    logic [2:0]  nzp;
    logic        wr;
    int          halts;
    int          fetches;
    for (int i = 0; i < 65536; i++) begin
        rmem[i] = image[i];
    end
    for (int i = 0; i < 8; i++) begin
        r[i] = 16'h0000;
    end
    pc      = 16'h3000;
    nzp     = 3'b010;
    halts   = 0;
    fetches = 0;
    exp_cnt = 0;
    // BRnzp to itself ends the program on its second fetch
    while ((halts < 2) && (fetches < MAX_INSTR)) begin
        ir = rmem[pc];
        add_txn(1'b0, pc, 16'h0000);
        fetches++;
        if (ir == 16'h0FFF) begin
            halts++;
        end
        pc = pc + 16'd1;
        wr = 1'b0;
        v  = 16'h0000;
        case (ir[15:12])
            // add
            4'b0001: begin
                v  = r[ir[8:6]] + (ir[5] ? sign_extend(ir, 5) : r[ir[2:0]]);
                wr = 1'b1;
            end
            // and
            4'b0101: begin
                v  = r[ir[8:6]] & (ir[5] ? sign_extend(ir, 5) : r[ir[2:0]]);
                wr = 1'b1;
            end
            // not
            4'b1001: begin
                v  = ~r[ir[8:6]];
                wr = 1'b1;
            end
            // br taken when any masked flag is set
            4'b0000: begin
                if ((ir[11:9] & nzp) != 3'b000) begin
                    pc = pc + sign_extend(ir, 9);
                end
            end
            // jmp, ret
            4'b1100: pc = r[ir[8:6]];
            // jsr and jsrr take the target before r7 is written
            4'b0100: begin
                a    = ir[11] ? (pc + sign_extend(ir, 11)) : r[ir[8:6]];
                r[7] = pc;
                pc   = a;
            end
            // ld and ldr
            4'b0010, 4'b0110: begin
                a  = ir[14] ? (r[ir[8:6]] + sign_extend(ir, 6)) : (pc + sign_extend(ir, 9));
                v  = rmem[a];
                wr = 1'b1;
                add_txn(1'b0, a, v);
            end
            // lea
            4'b1110: begin
                v  = pc + sign_extend(ir, 9);
                wr = 1'b1;
            end
            // st and str
            4'b0011, 4'b0111: begin
                a       = ir[14] ? (r[ir[8:6]] + sign_extend(ir, 6)) : (pc + sign_extend(ir, 9));
                rmem[a] = r[ir[11:9]];
                add_txn(1'b1, a, r[ir[11:9]]);
            end
            // ldi, sti, trap, rti, reserved
            default: ;
        endcase
        if (wr) begin
            r[ir[11:9]] = v;
            // n whenever the sign bit is set
            if (v[15]) begin
                nzp = 3'b100;
            end else if (v == 16'h0000) begin
                nzp = 3'b010;
            end else begin
                nzp = 3'b001;
            end
        end
    end
    return fetches;
endfunction

////////////////////////////////////////////////////////////
// program images loaded at 16'h3000
////////////////////////////////////////////////////////////

function automatic void load_image(input int t);
    logic [15:0] prog [$];
    case (t)
        // imm and reg forms of add/and incl negative imm5 and not, then store r1..r6
        0: begin
            test_name = "operate";
            prog = '{16'h5260, 16'h126D, 16'h1479, 16'h1642, 16'h58C1, 16'h9CFF, 16'h5BBD,
                     16'h3240, 16'h3440, 16'h3640, 16'h3840, 16'h3A40, 16'h3C40, 16'h0FFF};
        end
        // n, z and p results each followed by BRn/BRz/BRp over a never-taken filler
        1: begin
            test_name = "branch";
            prog = '{16'h123F, 16'h0801, 16'h0000, 16'h0401, 16'h0000, 16'h0201, 16'h0000,
                     16'h5420, 16'h0801, 16'h0000, 16'h0401, 16'h0000, 16'h0201, 16'h0000,
                     16'h1625, 16'h0801, 16'h0000, 16'h0401, 16'h0000, 16'h0201, 16'h0000,
                     16'h0A01, 16'h0000, 16'h0C01, 16'h0000, 16'h3240, 16'h0FFF};
        end
        // ld +/-, lea, ldr +/-, lea negative
        2: begin
            test_name = "load";
            prog = '{16'h2230, 16'h25F0, 16'hE620, 16'h68C5, 16'h6AF8, 16'hEDFC,
                     16'h3240, 16'h3440, 16'h3640, 16'h3840, 16'h3A40, 16'h3C40, 16'h0FFF};
        end
        // str +/-, st negative, read back through ldr
        3: begin
            test_name = "store";
            prog = '{16'hE250, 16'h1429, 16'h96BF, 16'h7443, 16'h767E, 16'h37EC,
                     16'h6843, 16'h3840, 16'h0FFF};
        end
        // jsr to 3006, jsrr to 300a, each sub stores r7 and returns, jmp to halt
        4: begin
            test_name = "jump";
            prog = '{16'h4805, 16'hE408, 16'h4080, 16'hE605, 16'hC0C0, 16'h0000,
                     16'h3E40, 16'hC1C0, 16'h0000, 16'h0FFF, 16'h3E40, 16'hC1C0};
        end
        // trap, ldi, sti, rti and reserved between a write of r1 and its store
        default: begin
            test_name = "dropped opcode";
            prog = '{16'h1227, 16'hF025, 16'hA240, 16'hB240, 16'h8000, 16'hD000,
                     16'h3240, 16'h0FFF};
        end
    endcase
    // background differs for every address
    for (int a = 0; a < 65536; a++) begin
        image[a] = {a[7:0], a[15:8]} ^ 16'hC35A;
    end
    foreach (prog[i]) begin
        image[16'h3000 + i] = prog[i];
    end
endfunction

`endif

// ==== tb_lc3.sv ====
// testbench top for lc3_core: clock, reset, memory model, bus checker, watchdog, report
`timescale 1ns/1ps
`default_nettype none

module tb_lc3;

    import lc3_pkg::*;

    localparam int NUM_TESTS    = 6;
    localparam int RESET_CYCLES = 4;
    // fetch, decode, exec, mem and wb all at their longest
    localparam int WORST_CYCLES = 16;

    logic        clk = 1'b0;
    logic        rst_n = 1'b0;
    mem_req_t    mem_req;
    mem_rsp_t    mem_rsp = '0;

    logic [15:0] mem [0:65535];
    logic [31:0] lcg_state = 32'h69c19bb4;
    logic        busy = 1'b0;
    logic [1:0]  wait_cnt = 2'd0;

    int          exp_idx = 0;
    logic        test_done = 1'b0;
    int          checks = 0;
    int          errors = 0;
    int          tests_run = 0;
    int          watch_cycles = 0;
    logic        limit_set = 1'b0;

    `include "tb_lc3_model.svh"

    always #2 clk = ~clk;

    lc3_core dut0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    task automatic compare_value(input string name, input logic [15:0] got,
                                 input logic [15:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("error: %s is %h, expected %h", name, got, expected);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // memory model, 0 to 3 extra wait cycles per access
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin : mem_model
        logic [1:0] delay;
        delay = 2'd0;
        if (!rst_n) begin
            mem_rsp  <= '0;
            busy     <= 1'b0;
            wait_cnt <= 2'd0;
            // image of the next test
            for (int a = 0; a < 65536; a++) begin
                mem[a] <= image[a];
            end
        end else if (mem_rsp.valid) begin
            // this edge completes the access
            mem_rsp.valid <= 1'b0;
            busy          <= 1'b0;
        end else if (mem_req.valid) begin
            if (!busy) begin
                lcg_state = lcg_next(lcg_state);
                delay     = lcg_state[17:16];
            end else begin
                delay = wait_cnt;
            end
            busy     <= 1'b1;
            wait_cnt <= delay - 2'd1;
            if (delay == 2'd0) begin
                mem_rsp.valid <= 1'b1;
                mem_rsp.rdata <= mem[mem_req.addr];
                if (mem_req.we) begin
                    mem[mem_req.addr] <= mem_req.wdata;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // bus checker, one compare per completed access
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin : bus_check
        bus_txn_t want;
        if (!rst_n) begin
            exp_idx = 0;
            test_done <= 1'b0;
        end else if (!test_done && mem_req.valid && mem_rsp.valid) begin
            want = exp_txn[exp_idx];
            compare_value("mem_req.addr", mem_req.addr, want.addr);
            compare_value("mem_req.we", {15'd0, mem_req.we}, {15'd0, want.we});
            if (want.we) begin
                compare_value("mem_req.wdata", mem_req.wdata, want.data);
            end
            exp_idx++;
            // last entry is the second fetch of the halt loop
            if (exp_idx >= exp_cnt) begin
                test_done <= 1'b1;
            end
        end
    end

    initial begin : watchdog
        wait (limit_set);
        repeat (watch_cycles) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", watch_cycles);
        $display("Finished with errors");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin : main
        int instr_total;
        int err_start;
        instr_total = 0;
        // dry run of every program sizes the watchdog
        for (int t = 0; t < NUM_TESTS; t++) begin
            load_image(t);
            instr_total += run_model();
        end
        watch_cycles = instr_total * WORST_CYCLES + NUM_TESTS * (RESET_CYCLES + 8);
        limit_set = 1'b1;
        for (int t = 0; t < NUM_TESTS; t++) begin
            load_image(t);
            void'(run_model());
            err_start = errors;
            @(posedge clk);
            rst_n <= 1'b0;
            repeat (RESET_CYCLES) @(posedge clk);
            rst_n <= 1'b1;
            wait (test_done);
            tests_run++;
            $display("test %0d %s: %0d bus transactions, %0d errors",
                     t, test_name, exp_cnt, errors - err_start);
        end
        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== lc3_core.f ====
+incdir+.
lc3_pkg.sv
lc3_regfile.sv
lc3_alu.sv
lc3_addr_gen.sv
lc3_writeback.sv
lc3_control.sv
lc3_core.sv
tb_lc3.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_lc3
FILELIST  ?= lc3_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Finished with no errors
FAIL_MSG  := Finished with errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(FAIL_MSG)" $(LOG) || ! grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
